//--- verilog/decim_pkg.sv
package decim_pkg;

  localparam int sample_w   = 16;
  localparam int word_w     = 32;
  localparam int ratio_w    = 8;
  localparam int count_w    = 16;
  localparam int fifo_depth = 8;

  // register port
  localparam int reg_addr_w = 2;
  localparam logic [reg_addr_w-1:0] addr_ratio  = reg_addr_w'(0);
  localparam logic [reg_addr_w-1:0] addr_enable = reg_addr_w'(1);
  localparam logic [reg_addr_w-1:0] addr_count  = reg_addr_w'(2); // read only

  typedef logic [sample_w-1:0] sample_t;
  typedef logic [word_w-1:0]   word_t;

endpackage

//--- verilog/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo
  import decim_pkg::*;
#(
  parameter type payload_t = sample_t,
  parameter int  depth     = fifo_depth
)
(
  input  logic     aclk,
  input  logic     aresetn,
  input  logic     s_valid,
  input  payload_t s_data,
  output logic     s_ready,
  output logic     m_valid,
  output payload_t m_data,
  input  logic     m_ready
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic [cnt_w-1:0] count_next;
  logic             wr_en;
  logic             rd_en;

  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign wr_en  = s_valid && s_ready;
  assign rd_en  = m_valid && m_ready;
  assign m_data = mem[rd_ptr];

  always_comb
  begin
    count_next = count;
    if (wr_en && !rd_en)
      count_next = count + 1'b1;
    else if (rd_en && !wr_en)
      count_next = count - 1'b1;
  end

  // flags registered from the next occupancy
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      s_ready <= 1'b0;
      m_valid <= 1'b0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= ptr_inc(wr_ptr);
      if (rd_en)
        rd_ptr <= ptr_inc(rd_ptr);
      count   <= count_next;
      s_ready <= (count_next != cnt_w'(depth));
      m_valid <= (count_next != '0);
    end
  end

  always_ff @(posedge aclk)
  begin
    if (wr_en)
      mem[wr_ptr] <= s_data;
  end

endmodule

//--- verilog/axis_decimator.sv
`timescale 1ns/1ps

module axis_decimator
  import decim_pkg::*;
(
  input  logic               aclk,
  input  logic               aresetn,
  input  logic [ratio_w-1:0] ratio,
  input  logic               enable,
  input  logic               restart,
  input  logic               s_valid,
  input  sample_t            s_data,
  output logic               s_ready,
  output logic               m_valid,
  output sample_t            m_data,
  input  logic               m_ready
);

  logic [ratio_w-1:0] phase;
  logic [ratio_w-1:0] phase_cur;
  logic               keep;
  logic               accept;
  logic               out_stall;

  // a sample arriving with restart is the first one of the new phase
  assign phase_cur = restart ? '0 : phase;
  assign keep      = (phase_cur == ratio);
  assign out_stall = m_valid && !m_ready;

  // dropped samples pass unless the kept slot is blocked
  assign s_ready = enable && !(keep && out_stall);
  assign accept  = s_valid && s_ready;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      phase   <= '0;
      m_valid <= 1'b0;
    end
    else
    begin
      if (accept)
        phase <= keep ? '0 : phase_cur + 1'b1;
      else
        phase <= phase_cur;

      if (accept && keep)
        m_valid <= 1'b1;
      else if (m_ready)
        m_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (accept && keep)
      m_data <= s_data;
  end

endmodule

//--- verilog/sample_packer.sv
`timescale 1ns/1ps

module sample_packer
  import decim_pkg::*;
(
  input  logic    aclk,
  input  logic    aresetn,
  input  logic    restart,
  input  logic    s_valid,
  input  sample_t s_data,
  output logic    s_ready,
  output logic    m_valid,
  output word_t   m_data,
  input  logic    m_ready
);

  sample_t half;
  logic    half_valid;
  logic    half_cur;
  logic    accept;

  assign half_cur = half_valid && !restart;   // restart drops the held half
  assign s_ready  = !(m_valid && !m_ready);
  assign accept   = s_valid && s_ready;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      half_valid <= 1'b0;
      m_valid    <= 1'b0;
    end
    else
    begin
      if (accept)
        half_valid <= !half_cur;
      else
        half_valid <= half_cur;

      if (accept && half_cur)
        m_valid <= 1'b1;
      else if (m_ready)
        m_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (accept && !half_cur)
      half <= s_data;
    if (accept && half_cur)
      m_data <= {s_data, half};               // first sample low
  end

endmodule

//--- verilog/decim_ctrl.sv
`timescale 1ns/1ps

module decim_ctrl
  import decim_pkg::*;
(
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  cfg_wr,
  input  logic                  cfg_rd,
  input  logic [reg_addr_w-1:0] cfg_addr,
  input  logic [31:0]           cfg_wdata,
  output logic [31:0]           cfg_rdata,
  input  logic                  out_fire,
  output logic [ratio_w-1:0]    ratio,
  output logic                  enable,
  output logic                  restart
);

  logic [count_w-1:0] word_count;
  logic [31:0]        rd_value;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      ratio      <= '0;
      enable     <= 1'b0;
      restart    <= 1'b0;
      word_count <= '0;
    end
    else
    begin
      // one cycle pulse after any ratio write
      restart <= cfg_wr && (cfg_addr == addr_ratio);
      if (cfg_wr)
      begin
        case (cfg_addr)
          addr_ratio:  ratio  <= cfg_wdata[ratio_w-1:0];
          addr_enable: enable <= cfg_wdata[0];
          default: ;                               // count is read only
        endcase
      end
      if (out_fire)
        word_count <= word_count + 1'b1;           // wraps
    end
  end

  always_comb
  begin
    rd_value = '0;
    case (cfg_addr)
      addr_ratio:  rd_value[ratio_w-1:0] = ratio;
      addr_enable: rd_value[0]           = enable;
      addr_count:  rd_value[count_w-1:0] = word_count;
      default: ;
    endcase
  end

  // read data held until the next read
  always_ff @(posedge aclk)
  begin
    if (cfg_rd)
      cfg_rdata <= rd_value;
  end

endmodule

//--- verilog/decim_top.sv
`timescale 1ns/1ps

module decim_top
  import decim_pkg::*;
(
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  s_valid,
  input  sample_t               s_data,
  output logic                  s_ready,
  output logic                  m_valid,
  output word_t                 m_data,
  input  logic                  m_ready,
  input  logic                  cfg_wr,
  input  logic                  cfg_rd,
  input  logic [reg_addr_w-1:0] cfg_addr,
  input  logic [31:0]           cfg_wdata,
  output logic [31:0]           cfg_rdata
);

  logic [ratio_w-1:0] ratio;
  logic               enable;
  logic               restart;
  logic               out_fire;

  logic    fi_valid;   // input fifo to decimator
  sample_t fi_data;
  logic    fi_ready;
  logic    dc_valid;   // decimator to packer
  sample_t dc_data;
  logic    dc_ready;
  logic    pk_valid;   // packer to output fifo
  word_t   pk_data;
  logic    pk_ready;

  assign out_fire = m_valid & m_ready;

  decim_ctrl u_ctrl (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .cfg_wr    (cfg_wr),
    .cfg_rd    (cfg_rd),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .out_fire  (out_fire),
    .ratio     (ratio),
    .enable    (enable),
    .restart   (restart)
  );

  stream_fifo #(
    .payload_t (sample_t),
    .depth     (fifo_depth)
  ) u_in_fifo (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (s_valid),
    .s_data  (s_data),
    .s_ready (s_ready),
    .m_valid (fi_valid),
    .m_data  (fi_data),
    .m_ready (fi_ready)
  );

  axis_decimator u_decim (
    .aclk    (aclk),
    .aresetn (aresetn),
    .ratio   (ratio),
    .enable  (enable),
    .restart (restart),
    .s_valid (fi_valid),
    .s_data  (fi_data),
    .s_ready (fi_ready),
    .m_valid (dc_valid),
    .m_data  (dc_data),
    .m_ready (dc_ready)
  );

  sample_packer u_pack (
    .aclk    (aclk),
    .aresetn (aresetn),
    .restart (restart),
    .s_valid (dc_valid),
    .s_data  (dc_data),
    .s_ready (dc_ready),
    .m_valid (pk_valid),
    .m_data  (pk_data),
    .m_ready (pk_ready)
  );

  stream_fifo #(
    .payload_t (word_t),
    .depth     (fifo_depth)
  ) u_out_fifo (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (pk_valid),
    .s_data  (pk_data),
    .s_ready (pk_ready),
    .m_valid (m_valid),
    .m_data  (m_data),
    .m_ready (m_ready)
  );

endmodule

//--- test/decim_checker.sv
`timescale 1ns/1ps

module decim_checker
  import decim_pkg::*;
(
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  s_valid,
  input  sample_t               s_data,
  input  logic                  s_ready,
  input  logic                  m_valid,
  input  word_t                 m_data,
  input  logic                  m_ready,
  input  logic                  cfg_wr,
  input  logic                  cfg_rd,
  input  logic [reg_addr_w-1:0] cfg_addr,
  input  logic [31:0]           cfg_wdata,
  input  logic [31:0]           cfg_rdata,
  output int                    pending,
  output int                    errors,
  output int                    words
);

  word_t              exp_q[$];
  logic [ratio_w-1:0] ratio_m;
  logic [ratio_w-1:0] phase_m;
  logic               enable_m;
  sample_t            half_m;
  logic               half_ok;
  int                 held;        // inputs taken while disabled
  logic               rd_pend;
  logic [31:0]        rd_exp;
  logic               stall_q;
  word_t              stall_data;
  word_t              exp_word;

  function automatic logic [31:0] read_model(input logic [reg_addr_w-1:0] a);
    case (a)
      addr_ratio:  return 32'(ratio_m);
      addr_enable: return 32'(enable_m);
      addr_count:  return 32'(words[count_w-1:0]);
      default:     return '0;
    endcase
  endfunction

  // pairs kept samples, first one low
  task automatic keep_sample(input sample_t d);
    if (half_ok)
    begin
      exp_q.push_back({d, half_m});
      half_ok = 1'b0;
    end
    else
    begin
      half_m  = d;
      half_ok = 1'b1;
    end
  endtask

  always @(posedge aclk)
  begin
    if (!aresetn)
    begin
      exp_q.delete();
      ratio_m    = '0;
      phase_m    = '0;
      enable_m   = 1'b0;
      half_ok    = 1'b0;
      held       = 0;
      rd_pend    = 1'b0;
      rd_exp     = '0;
      stall_q    = 1'b0;
      stall_data = '0;
      errors     = 0;
      words      = 0;
    end
    else
    begin
      if (rd_pend && cfg_rdata !== rd_exp)
      begin
        errors++;
        $display("FAILED cfg_rdata expected 0x%08h actual 0x%08h", rd_exp, cfg_rdata);
      end
      rd_pend = cfg_rd;
      if (cfg_rd)
        rd_exp = read_model(cfg_addr);

      if (stall_q && !m_valid)
      begin
        errors++;
        $display("m_valid dropped while m_ready was low");
      end
      else if (stall_q && m_data !== stall_data)
      begin
        errors++;
        $display("FAILED m_data expected 0x%08h actual 0x%08h", stall_data, m_data);
      end
      stall_q    = m_valid && !m_ready;
      stall_data = m_data;

      if (!enable_m && m_valid)
      begin
        errors++;
        $display("output word offered while the channel is disabled");
      end
      if (!enable_m && held >= fifo_depth && s_ready)
      begin
        errors++;
        $display("s_ready high although the input FIFO is full and the channel is disabled");
      end

      if (m_valid && m_ready)
      begin
        if (exp_q.size() == 0)
        begin
          errors++;
          $display("unexpected output word 0x%08h with no word pending", m_data);
        end
        else
        begin
          exp_word = exp_q.pop_front();
          if (m_data !== exp_word)
          begin
            errors++;
            $display("FAILED m_data expected 0x%08h actual 0x%08h", exp_word, m_data);
          end
        end
        words++;
      end

      if (cfg_wr && cfg_addr == addr_ratio)
      begin
        ratio_m = cfg_wdata[ratio_w-1:0];
        phase_m = '0;                       // restart
        half_ok = 1'b0;
      end
      else if (cfg_wr && cfg_addr == addr_enable)
        enable_m = cfg_wdata[0];

      if (s_valid && s_ready)
      begin
        if (!enable_m)
          held++;
        if (phase_m == ratio_m)
        begin
          phase_m = '0;
          keep_sample(s_data);
        end
        else
          phase_m++;
      end
    end
    pending = exp_q.size();
  end

endmodule

//--- test/tb_decim.sv
`timescale 1ns/1ps

module tb_decim
  import decim_pkg::*;
();

  localparam int          clk_period    = 100;
  localparam int          phase_samples = 64;
  localparam int          num_phases    = 5;
  localparam int          limit_cycles  = num_phases * phase_samples * 200 + 2000;
  localparam int          drain_cycles  = 2 * fifo_depth;   // trailing dropped samples
  localparam logic [31:0] lfsr_seed     = 32'h22636286;

  logic                  aclk;
  logic                  aresetn;
  logic                  s_valid;
  sample_t               s_data;
  logic                  s_ready;
  logic                  m_valid;
  word_t                 m_data;
  logic                  m_ready;
  logic                  cfg_wr;
  logic                  cfg_rd;
  logic [reg_addr_w-1:0] cfg_addr;
  logic [31:0]           cfg_wdata;
  logic [31:0]           cfg_rdata;
  int                    pending;
  int                    errors;
  int                    words;

  logic [31:0] stim_state  = lfsr_seed;
  logic [31:0] ready_state = lfsr_seed;
  logic        ready_mostly_low = 1'b0;
  int          ready_hold;

  decim_top u_dut (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .s_valid   (s_valid),
    .s_data    (s_data),
    .s_ready   (s_ready),
    .m_valid   (m_valid),
    .m_data    (m_data),
    .m_ready   (m_ready),
    .cfg_wr    (cfg_wr),
    .cfg_rd    (cfg_rd),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata)
  );

  decim_checker u_chk (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .s_valid   (s_valid),
    .s_data    (s_data),
    .s_ready   (s_ready),
    .m_valid   (m_valid),
    .m_data    (m_data),
    .m_ready   (m_ready),
    .cfg_wr    (cfg_wr),
    .cfg_rd    (cfg_rd),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .pending   (pending),
    .errors    (errors),
    .words     (words)
  );

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_stim(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      stim_state = lfsr_step(stim_state);
      v = {v[30:0], stim_state[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] rand_ready(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      ready_state = lfsr_step(ready_state);
      v = {v[30:0], ready_state[0]};
    end
    return v;
  endfunction

  task automatic tick();
    @(posedge aclk);
    #1;
  endtask

  task automatic write_reg(input logic [reg_addr_w-1:0] a, input logic [31:0] d);
    cfg_wr    = 1'b1;
    cfg_addr  = a;
    cfg_wdata = d;
    tick();
    cfg_wr    = 1'b0;
  endtask

  task automatic read_reg(input logic [reg_addr_w-1:0] a);
    cfg_rd   = 1'b1;
    cfg_addr = a;
    tick();
    cfg_rd   = 1'b0;
  endtask

  task automatic send_samples(input int n);
    for (int i = 0; i < n; i++)
    begin
      while (rand_stim(2) == 0)             // idle gap
        tick();
      s_valid = 1'b1;
      s_data  = sample_t'(rand_stim(16));
      while (!s_ready)
        tick();
      tick();
      s_valid = 1'b0;
    end
  endtask

  task automatic drain();
    while (pending != 0)
      tick();
    repeat (drain_cycles) tick();
  endtask

  task automatic run_phase(input int r, input int n);
    write_reg(addr_ratio, 32'(r));
    send_samples(n);
    drain();
  endtask

  task automatic wait_for_stall();
    while (!s_ready)
      tick();
    while (s_ready)
      tick();
  endtask

  initial
  begin
    aclk = 1'b0;
    forever #(clk_period / 2) aclk = ~aclk;
  end

  initial
  begin
    repeat (limit_cycles) @(posedge aclk);
    $display("timeout: run did not finish within %0d cycles", limit_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

  // random m_ready phases
  initial
  begin
    m_ready    = 1'b0;
    ready_hold = 0;
    tick();
    forever
    begin
      if (ready_hold > 0)
        ready_hold--;
      else if (ready_mostly_low)
      begin
        m_ready    = (rand_ready(3) == 0);
        ready_hold = int'(rand_ready(5));
      end
      else
      begin
        m_ready    = (rand_ready(2) != 0);
        ready_hold = int'(rand_ready(3));
      end
      tick();
    end
  end

  initial
  begin
    aresetn   = 1'b0;
    s_valid   = 1'b0;
    s_data    = '0;
    cfg_wr    = 1'b0;
    cfg_rd    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    repeat (4) @(posedge aclk);
    #1;
    aresetn = 1'b1;

    // disabled at first, input fifo fills and stalls
    write_reg(addr_ratio, 32'd0);
    fork
      send_samples(phase_samples);
      begin
        wait_for_stall();
        repeat (20) tick();
        write_reg(addr_enable, 32'd1);
      end
    join
    drain();

    run_phase(3, phase_samples);
    run_phase(7, phase_samples);
    ready_mostly_low = 1'b1;
    run_phase(1, phase_samples);
    ready_mostly_low = 1'b0;
    run_phase(2, 34);                       // leaves a half word and a phase behind
    run_phase(4, phase_samples - 34);

    read_reg(addr_ratio);
    read_reg(addr_enable);
    read_reg(addr_count);
    read_reg(2'd3);
    tick();

    $display("errors: %0d, words checked: %0d", errors, words);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- verilog.f
verilog/decim_pkg.sv
verilog/stream_fifo.sv
verilog/axis_decimator.sv
verilog/sample_packer.sv
verilog/decim_ctrl.sv
verilog/decim_top.sv
test/decim_checker.sv
test/tb_decim.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the decimator testbench with Verilator, run it and look for the pass line

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_decim -f verilog.f \
  --Mdir obj_dir -o sim_decim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_decim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "RESULT: PASS"; then
  exit 0
else
  exit 1
fi
